// ==== hdl/alu_logic.sv ====
`default_nettype none

module alu_logic (
    input  exec_pkg::op_t   op,
    input  exec_pkg::word_t src1,
    input  exec_pkg::word_t src2,
    input  exec_pkg::word_t hi,
    input  exec_pkg::word_t lo,
    output exec_pkg::word_t result,
    output logic            overflow
);
    import exec_pkg::*;

    shamt_t shamt;
    word_t  sum;
    word_t  diff;
    logic   add_ovf;
    logic   sub_ovf;

    assign shamt = src1[4:0];  // shift amount comes from src1
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;

    // pos + pos = neg, or neg + neg = pos
    assign add_ovf = (src1[31] == src2[31]) && (sum[31] != src1[31]);
    // pos - neg = neg, or neg - pos = pos
    assign sub_ovf = (src1[31] != src2[31]) && (diff[31] != src1[31]);

    always_comb begin
        case (op)
            OP_ADD, OP_ADDU: begin
                result = sum;  // wrapped sum even on overflow
            end
            OP_SUB, OP_SUBU: begin
                result = diff;
            end
            OP_SLT: begin
                result = {31'b0, $signed(src1) < $signed(src2)};
            end
            OP_SLTU: begin
                result = {31'b0, src1 < src2};
            end
            OP_AND:  result = src1 & src2;
            OP_OR:   result = src1 | src2;
            OP_NOR:  result = ~(src1 | src2);
            OP_XOR:  result = src1 ^ src2;
            OP_SLL:  result = src2 << shamt;
            OP_SRL:  result = src2 >> shamt;
            OP_SRA: begin
                result = $signed(src2) >>> shamt;  // sign fill
            end
            OP_LUI: begin
                result = {src2[15:0], 16'b0};
            end
            OP_MFHI: result = hi;
            OP_MFLO: result = lo;
            default: begin
                // mult/div/mthi/mtlo report zero
                result = '0;
            end
        endcase
    end

    // only the trapping forms flag overflow
    assign overflow = ((op == OP_ADD) && add_ovf) || ((op == OP_SUB) && sub_ovf);

endmodule

`default_nettype wire

// ==== hdl/div_iter.sv ====
`default_nettype none

module div_iter (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             is_signed,
    input  exec_pkg::word_t  dividend,
    input  exec_pkg::word_t  divisor,
    output logic             busy,
    output logic             done,
    output exec_pkg::dword_t rem_quot
);
    import exec_pkg::*;

    word_t       dvd_mag;
    word_t       dvs_mag;
    word_t       q_r;     // dividend shifts out, quotient shifts in
    word_t       rem_r;
    word_t       dvs_r;
    logic        neg_q;
    logic        neg_r;
    logic [5:0]  cnt;
    logic [32:0] trial;
    word_t       quot;
    word_t       rmd;

    assign dvd_mag = (is_signed && dividend[31]) ? -dividend : dividend;
    assign dvs_mag = (is_signed && divisor[31]) ? -divisor : divisor;

    // partial remainder with next dividend bit, minus divisor
    assign trial = {rem_r, q_r[31]} - {1'b0, dvs_r};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 6'd1;
                if (cnt == 6'd31) begin  // last quotient bit
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_r   <= dvd_mag;
            rem_r <= '0;
            dvs_r <= dvs_mag;
            neg_q <= is_signed && (dividend[31] ^ divisor[31]);
            neg_r <= is_signed && dividend[31];
        end else if (busy) begin
            if (!trial[32]) begin
                rem_r <= trial[31:0];
                q_r   <= {q_r[30:0], 1'b1};
            end else begin
                // restore, keep the shifted remainder
                rem_r <= {rem_r[30:0], q_r[31]};
                q_r   <= {q_r[30:0], 1'b0};
            end
        end
    end

    // zero divisor never fails the trial, so quotient ends all ones
    assign quot     = neg_q ? -q_r : q_r;
    assign rmd      = neg_r ? -rem_r : rem_r;  // remainder follows dividend sign
    assign rem_quot = {rmd, quot};

    // top must wait for done before issuing another divide
    no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    typedef logic [31:0] word_t;   // operand / result / hi / lo
    typedef logic [63:0] dword_t;  // product or {remainder, quotient}
    typedef logic [4:0]  shamt_t;
    typedef logic [4:0]  op_t;

    // trapping forms, may raise overflow
    localparam op_t OP_ADD   = 5'd0;
    localparam op_t OP_SUB   = 5'd1;

    localparam op_t OP_ADDU  = 5'd2;
    localparam op_t OP_SUBU  = 5'd3;
    localparam op_t OP_SLT   = 5'd4;
    localparam op_t OP_SLTU  = 5'd5;
    localparam op_t OP_AND   = 5'd6;
    localparam op_t OP_OR    = 5'd7;
    localparam op_t OP_NOR   = 5'd8;
    localparam op_t OP_XOR   = 5'd9;
    localparam op_t OP_SLL   = 5'd10;
    localparam op_t OP_SRL   = 5'd11;
    localparam op_t OP_SRA   = 5'd12;
    localparam op_t OP_LUI   = 5'd13;

    // multi-cycle, results land in hi/lo
    localparam op_t OP_MULT  = 5'd14;
    localparam op_t OP_MULTU = 5'd15;
    localparam op_t OP_DIV   = 5'd16;
    localparam op_t OP_DIVU  = 5'd17;

    localparam op_t OP_MFHI  = 5'd18;
    localparam op_t OP_MFLO  = 5'd19;
    localparam op_t OP_MTHI  = 5'd20;
    localparam op_t OP_MTLO  = 5'd21;

    typedef enum logic [1:0] {
        IDLE,
        MUL_WAIT,
        DIV_WAIT,
        RESP
    } exec_state_t;

endpackage

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`default_nettype none

module exec_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            op_valid,
    output logic            op_ready,
    input  exec_pkg::op_t   op,
    input  exec_pkg::word_t src1,
    input  exec_pkg::word_t src2,
    output logic            result_valid,
    input  logic            result_ready,
    output exec_pkg::word_t result,
    output logic            overflow
);
    import exec_pkg::*;

    exec_state_t state;
    logic        accept;
    logic        is_mul;
    logic        is_div;
    word_t       opa_q;      // operands held for the multi-cycle units
    word_t       opb_q;
    logic        signed_q;
    logic        mul_start;
    logic        div_start;
    logic        mul_done;
    logic        div_busy;
    logic        div_done;
    dword_t      product;
    dword_t      rem_quot;
    logic        pair_write;
    dword_t      pair;
    logic        hi_write;
    logic        lo_write;
    word_t       hi;
    word_t       lo;
    word_t       alu_result;
    logic        alu_ovf;

    assign op_ready     = (state == IDLE) && !div_busy;
    assign result_valid = (state == RESP);
    assign accept       = op_valid && op_ready;
    assign is_mul       = (op == OP_MULT) || (op == OP_MULTU);
    assign is_div       = (op == OP_DIV) || (op == OP_DIVU);

    assign hi_write = accept && (op == OP_MTHI);
    assign lo_write = accept && (op == OP_MTLO);

    // unit finished, commit its 64-bit result
    assign pair_write = ((state == MUL_WAIT) && mul_done) || ((state == DIV_WAIT) && div_done);
    assign pair       = (state == DIV_WAIT) ? rem_quot : product;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= accept && is_mul;  // one-cycle strobes
            div_start <= accept && is_div;
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (is_mul) state <= MUL_WAIT;
                        else if (is_div) state <= DIV_WAIT;
                        else state <= RESP;
                    end
                end
                MUL_WAIT: if (mul_done) state <= RESP;
                DIV_WAIT: if (div_done) state <= RESP;
                RESP:     if (result_ready) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opa_q    <= src1;
            opb_q    <= src2;
            signed_q <= (op == OP_MULT) || (op == OP_DIV);
            result   <= alu_result;  // mfhi/mflo sample hi/lo here
            overflow <= alu_ovf;
        end else if (pair_write) begin
            result   <= '0;
            overflow <= 1'b0;
        end
    end

    alu_logic u_alu (
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .hi       (hi),
        .lo       (lo),
        .result   (alu_result),
        .overflow (alu_ovf)
    );

    mul_pipe #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul (
        .clk       (clk),
        .reset     (reset),
        .start     (mul_start),
        .is_signed (signed_q),
        .a         (opa_q),
        .b         (opb_q),
        .product   (product),
        .done      (mul_done)
    );

    div_iter u_div (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (signed_q),
        .dividend  (opa_q),
        .divisor   (opb_q),
        .busy      (div_busy),
        .done      (div_done),
        .rem_quot  (rem_quot)
    );

    hilo_regs u_hilo (
        .clk        (clk),
        .reset      (reset),
        .pair_write (pair_write),
        .pair       (pair),
        .hi_write   (hi_write),
        .lo_write   (lo_write),
        .src        (src1),
        .hi         (hi),
        .lo         (lo)
    );

    // response held under back-pressure
    resp_stable: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result) && $stable(overflow));

endmodule

`default_nettype wire

// ==== hdl/hilo_regs.sv ====
`default_nettype none

module hilo_regs (
    input  logic             clk,
    input  logic             reset,
    input  logic             pair_write,
    input  exec_pkg::dword_t pair,
    input  logic             hi_write,
    input  logic             lo_write,
    input  exec_pkg::word_t  src,
    output exec_pkg::word_t  hi,
    output exec_pkg::word_t  lo
);
    import exec_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (pair_write) begin
            // product halves, or remainder / quotient
            hi <= pair[63:32];
            lo <= pair[31:0];
        end else if (hi_write) begin
            hi <= src;   // mthi
        end else if (lo_write) begin
            lo <= src;   // mtlo
        end
    end

    // the control FSM only ever raises one of these
    one_write_only: assert property (@(posedge clk) disable iff (reset)
        $onehot0({pair_write, hi_write, lo_write}));

endmodule

`default_nettype wire

// ==== hdl/mul_pipe.sv ====
`default_nettype none

module mul_pipe #(
    parameter int MUL_STAGES = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             is_signed,
    input  exec_pkg::word_t  a,
    input  exec_pkg::word_t  b,
    output exec_pkg::dword_t product,
    output logic             done
);
    import exec_pkg::*;

    word_t                  a_mag;
    word_t                  b_mag;
    logic                   neg_in;
    logic [MUL_STAGES-1:0]  vld;   // valid bit per stage
    logic [MUL_STAGES-1:0]  neg;   // negate flag travels with the data
    dword_t                 prod [MUL_STAGES];

    // unsigned core, signs folded out at the input
    assign a_mag  = (is_signed && a[31]) ? -a : a;
    assign b_mag  = (is_signed && b[31]) ? -b : b;
    assign neg_in = is_signed && (a[31] ^ b[31]);

    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld[0] <= start;
            for (int i = 1; i < MUL_STAGES; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        prod[0] <= dword_t'(a_mag) * dword_t'(b_mag);
        neg[0]  <= neg_in;
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod[i] <= prod[i-1];
            neg[i]  <= neg[i-1];
        end
    end

    // sign restored on the way out of the last stage
    assign product = neg[MUL_STAGES-1] ? -prod[MUL_STAGES-1] : prod[MUL_STAGES-1];
    assign done    = vld[MUL_STAGES-1];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module exec_unit_tb -o exec_unit_sim
./obj_dir/exec_unit_sim

// ==== sim/exec_unit_tb.sv ====
`default_nettype none

module exec_unit_tb;
    import exec_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int ROW_CYCLES   = 45;  // divide plus back-pressure fits well inside
    localparam int HOLD_CYCLES  = 3;

    logic  clk;
    logic  reset;
    logic  op_valid;
    logic  op_ready;
    op_t   op;
    word_t src1;
    word_t src2;
    logic  result_valid;
    logic  result_ready;
    word_t result;
    logic  overflow;

    op_t   tbl_op [$];
    word_t tbl_a [$];
    word_t tbl_b [$];
    bit    tbl_rnd [$];   // row takes both operands from the xorshift stream
    bit    rows_built;
    word_t rng;
    word_t model_hi;
    word_t model_lo;

    exec_unit #(
        .MUL_STAGES (3)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .op_ready     (op_ready),
        .op           (op),
        .src1         (src1),
        .src2         (src2),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .overflow     (overflow)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "flag compare failed");
        end
    endtask

    // reference model with its own hi/lo
    task automatic model_op(input op_t o, input word_t a, input word_t b,
                            output word_t res, output logic ovf);
        longint wide;
        dword_t prod;
        word_t  a_mag;
        word_t  b_mag;
        word_t  q;
        word_t  r;
        logic   sgn;
        res = '0;
        ovf = 1'b0;
        case (o)
            OP_ADD, OP_ADDU: begin
                res  = a + b;
                wide = longint'($signed(a)) + longint'($signed(b));
                ovf  = (o == OP_ADD) && ((wide > 64'sd2147483647) || (wide < -64'sd2147483648));
            end
            OP_SUB, OP_SUBU: begin
                res  = a - b;
                wide = longint'($signed(a)) - longint'($signed(b));
                ovf  = (o == OP_SUB) && ((wide > 64'sd2147483647) || (wide < -64'sd2147483648));
            end
            OP_SLT:  res = {31'b0, ($signed(a) < $signed(b))};
            OP_SLTU: res = {31'b0, (a < b)};
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_NOR:  res = ~(a | b);
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = b << a[4:0];
            OP_SRL:  res = b >> a[4:0];
            OP_SRA: begin
                res = b;
                repeat (a[4:0]) begin
                    res = {res[31], res[31:1]};  // one sign-filled step
                end
            end
            OP_LUI:  res = {b[15:0], 16'h0000};
            OP_MULT, OP_MULTU: begin
                if (o == OP_MULT) prod = dword_t'(longint'($signed(a)) * longint'($signed(b)));
                else prod = {32'b0, a} * {32'b0, b};
                model_hi = prod[63:32];
                model_lo = prod[31:0];
            end
            OP_DIV, OP_DIVU: begin
                sgn   = (o == OP_DIV);
                a_mag = (sgn && a[31]) ? -a : a;
                b_mag = (sgn && b[31]) ? -b : b;
                q     = (b_mag == '0) ? '1 : a_mag / b_mag;  // divide by zero gives all ones
                r     = (b_mag == '0) ? a_mag : a_mag % b_mag;
                model_lo = (sgn && (a[31] != b[31])) ? -q : q;
                model_hi = (sgn && a[31]) ? -r : r;
            end
            OP_MFHI: res = model_hi;
            OP_MFLO: res = model_lo;
            OP_MTHI: model_hi = a;
            OP_MTLO: model_lo = a;
            default: res = '0;
        endcase
    endtask

    task automatic add_row(input op_t o, input word_t a, input word_t b, input bit rnd);
        tbl_op.push_back(o);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_rnd.push_back(rnd);
    endtask

    task automatic add_readback();
        add_row(OP_MFHI, 32'h0, 32'h0, 1'b0);
        add_row(OP_MFLO, 32'h0, 32'h0, 1'b0);
    endtask

    task automatic build_table();
        add_readback();  // hi/lo straight out of reset
        add_row(OP_ADD,   32'h7fffffff, 32'h00000001, 1'b0);
        add_row(OP_ADD,   32'h80000000, 32'hffffffff, 1'b0);
        add_row(OP_ADD,   32'hffffffff, 32'h00000001, 1'b0);
        add_row(OP_ADDU,  32'h7fffffff, 32'h00000001, 1'b0);
        add_row(OP_SUB,   32'h80000000, 32'h00000001, 1'b0);
        add_row(OP_SUB,   32'h7fffffff, 32'hffffffff, 1'b0);
        add_row(OP_SUB,   32'h00000005, 32'h00000003, 1'b0);
        add_row(OP_SUBU,  32'h80000000, 32'h00000001, 1'b0);
        add_row(OP_SLT,   32'hffffffff, 32'h00000001, 1'b0);
        add_row(OP_SLTU,  32'hffffffff, 32'h00000001, 1'b0);
        add_row(OP_AND,   32'h0, 32'h0, 1'b1);
        add_row(OP_OR,    32'h0, 32'h0, 1'b1);
        add_row(OP_NOR,   32'h0, 32'h0, 1'b1);
        add_row(OP_XOR,   32'h0, 32'h0, 1'b1);
        add_row(OP_SLL,   32'h00000004, 32'h00000001, 1'b0);
        add_row(OP_SRL,   32'h0000001f, 32'h80000000, 1'b0);
        add_row(OP_SRA,   32'h00000004, 32'hf0000000, 1'b0);
        add_row(OP_SRA,   32'h0, 32'h0, 1'b1);
        add_row(OP_LUI,   32'h00000000, 32'h1234abcd, 1'b0);
        add_row(OP_ADD,   32'h0, 32'h0, 1'b1);
        add_row(OP_SUB,   32'h0, 32'h0, 1'b1);
        add_row(OP_MULT,  32'hffffffff, 32'h00000007, 1'b0);
        add_readback();
        add_row(OP_MULTU, 32'hffffffff, 32'hffffffff, 1'b0);
        add_readback();
        add_row(OP_MULT,  32'h0, 32'h0, 1'b1);
        add_readback();
        add_row(OP_DIV,   32'hfffffff9, 32'h00000002, 1'b0);
        add_readback();
        add_row(OP_DIVU,  32'h0, 32'h0, 1'b1);
        add_readback();
        add_row(OP_DIV,   32'hfffffff9, 32'h00000000, 1'b0);
        add_readback();
        add_row(OP_DIVU,  32'h00000005, 32'h00000000, 1'b0);
        add_readback();
        add_row(OP_MTHI,  32'hdeadbeef, 32'h0, 1'b0);
        add_row(OP_MTLO,  32'h12345678, 32'h0, 1'b0);
        add_readback();
    endtask

    initial begin
        int limit;
        wait (rows_built);
        limit = (RESET_CYCLES + tbl_op.size() * ROW_CYCLES) * CLK_PERIOD;
        #(limit);
        $display("timeout: the unit stopped responding before the table was done");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int    i;
        word_t a;
        word_t b;
        word_t exp_res;
        logic  exp_ovf;
        clk          = 1'b0;
        reset        = 1'b1;
        op_valid     = 1'b0;
        op           = OP_ADDU;
        src1         = '0;
        src2         = '0;
        result_ready = 1'b1;
        rng          = 32'h6d26;
        model_hi     = '0;
        model_lo     = '0;
        build_table();
        rows_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (i = 0; i < tbl_op.size(); i++) begin
            a = tbl_a[i];
            b = tbl_b[i];
            if (tbl_rnd[i]) begin
                rng = xorshift(rng);
                a   = rng;
                rng = xorshift(rng);
                b   = rng;
            end
            op_valid     <= 1'b1;
            op           <= tbl_op[i];
            src1         <= a;
            src2         <= b;
            result_ready <= ((i % 3) != 2);  // every third row sees back-pressure
            @(negedge clk);
            while (!op_ready) begin
                @(negedge clk);
            end
            @(posedge clk);  // accept edge
            op_valid <= 1'b0;
            model_op(tbl_op[i], a, b, exp_res, exp_ovf);
            @(negedge clk);
            while (!result_valid) begin
                @(negedge clk);
            end
            check_word(result, exp_res, $sformatf("row %0d result", i));
            check_flag(overflow, exp_ovf, $sformatf("row %0d overflow", i));
            if ((i % 3) == 2) begin
                repeat (HOLD_CYCLES) begin
                    @(negedge clk);
                    check_flag(result_valid, 1'b1, $sformatf("row %0d held valid", i));
                    check_flag(op_ready, 1'b0, $sformatf("row %0d op_ready while held", i));
                    check_word(result, exp_res, $sformatf("row %0d held result", i));
                    check_flag(overflow, exp_ovf, $sformatf("row %0d held overflow", i));
                end
                @(posedge clk);
                result_ready <= 1'b1;
            end
            @(posedge clk);  // response taken here
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/exec_pkg.sv
hdl/alu_logic.sv
hdl/mul_pipe.sv
hdl/div_iter.sv
hdl/hilo_regs.sv
hdl/exec_unit.sv
sim/exec_unit_tb.sv
